/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - .
    files:
      - mem_stage_pkg.sv
      - mem_bus_if.sv
      - mem_lane_align.sv
      - mem_wb_master.sv
      - mem_access_ctrl.sv
      - mem_stage.sv
      - target: test
        files:
          - tb_wb_slave.sv
          - tb_mem_stage.sv

/* build.f */
+incdir+.
mem_stage_pkg.sv
mem_bus_if.sv
mem_lane_align.sv
mem_wb_master.sv
mem_access_ctrl.sv
mem_stage.sv
tb_wb_slave.sv
tb_mem_stage.sv

/* mem_access_ctrl.sv */
`default_nettype none

module mem_access_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  mem_stage_pkg::mem_op_e    req_op_i,
    input  mem_stage_pkg::word_t      req_addr_i,
    input  mem_stage_pkg::word_t      req_store_data_i,
    input  mem_stage_pkg::reg_addr_t  req_wd_i,
    input  logic                      req_wreg_i,
    input  mem_stage_pkg::word_t      req_wdata_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output mem_stage_pkg::reg_addr_t  res_wd_o,
    output logic                      res_wreg_o,
    output mem_stage_pkg::word_t      res_wdata_o,
    input  logic                      llbit_clr_i,
    mem_bus_if.ctrl                   bus
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_RESULT
    } state_e;

    state_e    state_q;
    logic      llbit_q;

    mem_op_e   op_q;
    word_t     addr_q;
    word_t     store_q;
    reg_addr_t wd_q;
    logic      wreg_q;
    word_t     wdata_q;

    mem_op_e   cur_op;
    word_t     cur_addr;
    word_t     cur_store;
    reg_addr_t cur_wd;
    logic      cur_wreg;
    word_t     cur_wdata;

    logic      idle;
    logic      accept;
    logic      lane_access;
    word_t     lane_load;
    logic      link_ok;
    logic      sc_skip;
    logic      need_bus;
    logic      is_load;
    logic      res_load;
    word_t     result_word;

    assign idle        = (state_q == S_IDLE);
    assign req_ready_o = idle;
    assign accept      = req_valid_i && idle;
    assign res_valid_o = (state_q == S_RESULT);

    // Live request while idle so the access can start in the accept cycle
    assign cur_op    = idle ? req_op_i         : op_q;
    assign cur_addr  = idle ? req_addr_i       : addr_q;
    assign cur_store = idle ? req_store_data_i : store_q;
    assign cur_wd    = idle ? req_wd_i         : wd_q;
    assign cur_wreg  = idle ? req_wreg_i       : wreg_q;
    assign cur_wdata = idle ? req_wdata_i      : wdata_q;

    mem_lane_align i_lane_align (
        .op_i          (cur_op),
        .addr_i        (cur_addr),
        .store_data_i  (cur_store),
        .load_word_i   (bus.dat_r),
        .sel_o         (bus.sel),
        .store_word_o  (bus.dat_w),
        .load_result_o (lane_load),
        .bus_access_o  (lane_access)
    );

    assign link_ok  = !idle || llbit_q;                     // An SC in flight already passed
    assign sc_skip  = (cur_op == OP_SC) && !link_ok;
    assign need_bus = lane_access && !sc_skip;

    assign bus.start = accept && need_bus;
    assign bus.adr   = cur_addr;
    assign bus.we    = cur_op inside {OP_SB, OP_SH, OP_SW, OP_SC};

    assign is_load  = cur_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LL};
    assign res_load = (accept && !need_bus) || ((state_q == S_BUS) && bus.done);

    always_comb begin
        if (is_load) begin
            result_word = lane_load;
        end else if (cur_op == OP_SC) begin
            result_word = word_t'(link_ok);                 // 1 on success and 0 on failure
        end else begin
            result_word = cur_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:   if (accept)      state_q <= need_bus ? S_BUS : S_RESULT;
                S_BUS:    if (bus.done)    state_q <= S_RESULT;
                S_RESULT: if (res_ready_i) state_q <= S_IDLE;
                default:                   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            llbit_q <= 1'b0;
        end else if (llbit_clr_i) begin
            llbit_q <= 1'b0;
        end else if (accept && (req_op_i == OP_LL)) begin
            llbit_q <= 1'b1;
        end else if (bus.start && (req_op_i == OP_SC)) begin
            llbit_q <= 1'b0;                                // A successful SC consumes the link
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            store_q <= req_store_data_i;
            wd_q    <= req_wd_i;
            wreg_q  <= req_wreg_i;
            wdata_q <= req_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (res_load) begin
            res_wd_o    <= cur_wd;
            res_wreg_o  <= cur_wreg;
            res_wdata_o <= result_word;
        end
    end

endmodule

`default_nettype wire

/* mem_bus_if.sv */
`default_nettype none

interface mem_bus_if;
    import mem_stage_pkg::*;

    logic  start; // One-cycle pulse that launches an access
    logic  we;
    word_t adr;
    sel_t  sel;
    word_t dat_w;
    logic  done;  // One-cycle pulse when the access completes
    word_t dat_r;

    modport ctrl (
        output start,
        output we,
        output adr,
        output sel,
        output dat_w,
        input  done,
        input  dat_r
    );

    modport master (
        input  start,
        input  we,
        input  adr,
        input  sel,
        input  dat_w,
        output done,
        output dat_r
    );

endinterface

`default_nettype wire

/* mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Sizes shared by the memory stage and its testbench

`define MEM_XLEN     32 // Data and address word width
`define MEM_REG_AW   5  // Destination register number width
`define MEM_LANES    4  // Byte lanes per word
`define MEM_TB_DEPTH 64 // Words in the testbench memory model

`endif

/* mem_lane_align.sv */
`default_nettype none

`include "mem_config.svh"

module mem_lane_align (
    input  mem_stage_pkg::mem_op_e op_i,
    input  mem_stage_pkg::word_t   addr_i,
    input  mem_stage_pkg::word_t   store_data_i,
    input  mem_stage_pkg::word_t   load_word_i,
    output mem_stage_pkg::sel_t    sel_o,
    output mem_stage_pkg::word_t   store_word_o,
    output mem_stage_pkg::word_t   load_result_o,
    output logic                   bus_access_o
);
    import mem_stage_pkg::*;

    logic [1:0]  offset;
    logic        half_misaligned;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    sel_t        byte_sel;
    sel_t        half_sel;

    assign offset          = addr_i[1:0];
    assign half_misaligned = offset[0];
    assign byte_sel        = 4'b1000 >> offset;                  // Offset 0 is the MSB lane
    assign half_sel        = offset[1] ? 4'b0011 : 4'b1100;
    assign lane_half       = offset[1] ? load_word_i[15:0] : load_word_i[31:16];

    always_comb begin
        case (offset)
            2'd0:    lane_byte = load_word_i[31:24];
            2'd1:    lane_byte = load_word_i[23:16];
            2'd2:    lane_byte = load_word_i[15:8];
            default: lane_byte = load_word_i[7:0];
        endcase
    end

    always_comb begin
        sel_o         = '0;
        store_word_o  = store_data_i;
        load_result_o = '0;
        bus_access_o  = 1'b1;
        case (op_i)
            OP_LB, OP_LBU: begin
                sel_o         = byte_sel;
                load_result_o = (op_i == OP_LB) ? {{(`MEM_XLEN-8){lane_byte[7]}}, lane_byte}
                                                : {{(`MEM_XLEN-8){1'b0}}, lane_byte};
            end
            OP_LH, OP_LHU: begin
                if (half_misaligned) begin
                    bus_access_o = 1'b0;                         // Result stays zero
                end else begin
                    sel_o         = half_sel;
                    load_result_o = (op_i == OP_LH) ? {{(`MEM_XLEN-16){lane_half[15]}}, lane_half}
                                                    : {{(`MEM_XLEN-16){1'b0}}, lane_half};
                end
            end
            OP_LW, OP_LL: begin
                sel_o         = '1;
                load_result_o = load_word_i;
            end
            OP_SB: begin
                sel_o        = byte_sel;
                store_word_o = {4{store_data_i[7:0]}};
            end
            OP_SH: begin
                if (half_misaligned) begin
                    bus_access_o = 1'b0;
                end else begin
                    sel_o        = half_sel;
                    store_word_o = {2{store_data_i[15:0]}};
                end
            end
            OP_SW, OP_SC: begin
                sel_o = '1;
            end
            default: begin
                bus_access_o = 1'b0;                             // OP_NONE never touches the bus
            end
        endcase
    end

endmodule

`default_nettype wire

/* mem_stage.sv */
`default_nettype none

module mem_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  mem_stage_pkg::mem_op_e    req_op_i,
    input  mem_stage_pkg::word_t      req_addr_i,
    input  mem_stage_pkg::word_t      req_store_data_i,
    input  mem_stage_pkg::reg_addr_t  req_wd_i,
    input  logic                      req_wreg_i,
    input  mem_stage_pkg::word_t      req_wdata_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output mem_stage_pkg::reg_addr_t  res_wd_o,
    output logic                      res_wreg_o,
    output mem_stage_pkg::word_t      res_wdata_o,
    input  logic                      llbit_clr_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic                      wb_we_o,
    output mem_stage_pkg::word_t      wb_adr_o,
    output mem_stage_pkg::sel_t       wb_sel_o,
    output mem_stage_pkg::word_t      wb_dat_o,
    input  mem_stage_pkg::word_t      wb_dat_i,
    input  logic                      wb_ack_i
);

    mem_bus_if bus_if ();

    mem_access_ctrl i_mem_access_ctrl (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_op_i         (req_op_i),
        .req_addr_i       (req_addr_i),
        .req_store_data_i (req_store_data_i),
        .req_wd_i         (req_wd_i),
        .req_wreg_i       (req_wreg_i),
        .req_wdata_i      (req_wdata_i),
        .res_valid_o      (res_valid_o),
        .res_ready_i      (res_ready_i),
        .res_wd_o         (res_wd_o),
        .res_wreg_o       (res_wreg_o),
        .res_wdata_o      (res_wdata_o),
        .llbit_clr_i      (llbit_clr_i),
        .bus              (bus_if.ctrl)
    );

    mem_wb_master i_mem_wb_master (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus_if.master),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_o (wb_dat_o)
    );

endmodule

`default_nettype wire

/* mem_stage_pkg.sv */
`default_nettype none

`include "mem_config.svh"

package mem_stage_pkg;

    typedef logic [`MEM_XLEN-1:0]   word_t;     // One data or address word
    typedef logic [`MEM_LANES-1:0]  sel_t;      // One select bit per byte lane
    typedef logic [`MEM_REG_AW-1:0] reg_addr_t; // Register file index

    // Operations the execute stage can hand to this stage
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,  // Plain pass-through of the ALU result
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8,
        OP_LL   = 4'd9,  // Load word and set the link bit
        OP_SC   = 4'd10  // Store word only while the link bit is set
    } mem_op_e;

endpackage

`default_nettype wire

/* mem_wb_master.sv */
`default_nettype none

module mem_wb_master (
    input  logic                 clk,
    input  logic                 arst_n_i,
    mem_bus_if.master            bus,
    input  mem_stage_pkg::word_t wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output mem_stage_pkg::word_t wb_adr_o,
    output mem_stage_pkg::sel_t  wb_sel_o,
    output mem_stage_pkg::word_t wb_dat_o
);

    logic cycle_end;

    // A classic cycle ends in the cycle where the slave acknowledges the strobe
    assign cycle_end = wb_cyc_o && wb_stb_o && wb_ack_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else if (bus.start) begin
            wb_cyc_o <= 1'b1;                   // Cycle and strobe rise together
            wb_stb_o <= 1'b1;
            wb_we_o  <= bus.we;
        end else if (cycle_end) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end
    end

    // Address, select and write data are captured once and held through the wait states
    always_ff @(posedge clk) begin
        if (bus.start) begin
            wb_adr_o <= bus.adr;
            wb_sel_o <= bus.sel;
            wb_dat_o <= bus.dat_w;
        end
    end

    assign bus.done  = cycle_end;
    assign bus.dat_r = wb_dat_i;                // Sampled by the controller on done

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`default_nettype none

`include "mem_config.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_stage_pkg::*;

    localparam word_t SEED           = 32'hfc6d_84ba;
    localparam int    TIMEOUT_CYCLES = 200 * 12; // 200 requests of at most 12 cycles each
    localparam int    IDX_W          = $clog2(`MEM_TB_DEPTH);

    logic      clk;
    logic      arst_n_i;
    logic      req_valid_i;
    logic      req_ready_o;
    mem_op_e   req_op_i;
    word_t     req_addr_i;
    word_t     req_store_data_i;
    reg_addr_t req_wd_i;
    logic      req_wreg_i;
    word_t     req_wdata_i;
    logic      res_valid_o;
    logic      res_ready_i;
    reg_addr_t res_wd_o;
    logic      res_wreg_o;
    word_t     res_wdata_o;
    logic      llbit_clr_i;
    logic      wb_cyc_o;
    logic      wb_stb_o;
    logic      wb_we_o;
    word_t     wb_adr_o;
    sel_t      wb_sel_o;
    word_t     wb_dat_o;
    word_t     wb_dat_i;
    logic      wb_ack_i;

    logic [2:0] wait_states = 3'd0;
    word_t      wait_rng    = SEED ^ 32'h5555_5555;
    word_t      rng_state   = SEED;
    int         cycle_count = 0;
    int         value_errors = 0;
    int         protocol_errors = 0;

    // Bus monitor state
    int    bus_count = 0;
    word_t last_adr;
    sel_t  last_sel;
    word_t last_dat;
    logic  last_we;
    logic  prev_cyc = 1'b0;
    logic  held     = 1'b0;
    logic  prev_ack = 1'b0;

    // Expected memory contents and link bit
    word_t shadow [`MEM_TB_DEPTH];
    logic  exp_link = 1'b0;

    mem_stage i_mem_stage (.*);

    tb_wb_slave i_wb_slave (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .wb_cyc_i      (wb_cyc_o),
        .wb_stb_i      (wb_stb_o),
        .wb_we_i       (wb_we_o),
        .wb_adr_i      (wb_adr_o),
        .wb_sel_i      (wb_sel_o),
        .wb_dat_i      (wb_dat_o),
        .wait_states_i (wait_states),
        .wb_dat_o      (wb_dat_i),
        .wb_ack_o      (wb_ack_i)
    );

    always #10 clk = ~clk;

    function automatic word_t lcg_step(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function word_t next_random();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            value_errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        wait_rng    <= lcg_step(wait_rng);
        wait_states <= wait_rng[30:28];             // 0 to 7 wait states
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // Records each Wishbone cycle and checks that it is held until ack
    always @(negedge clk) begin
        if (arst_n_i) begin
            assert (wb_cyc_o == wb_stb_o) else report_protocol("wb_cyc_o and wb_stb_o differ");
            assert (!held || (wb_cyc_o && wb_stb_o))
                else report_protocol("wb_cyc_o or wb_stb_o dropped before ack");
            assert (!prev_ack || !wb_cyc_o) else report_protocol("wb_cyc_o still high after ack");
            if (wb_cyc_o && !prev_cyc) begin
                bus_count++;
                last_adr = wb_adr_o;
                last_sel = wb_sel_o;
                last_dat = wb_dat_o;
                last_we  = wb_we_o;
            end else if (wb_cyc_o) begin
                assert (wb_adr_o == last_adr && wb_sel_o == last_sel && wb_dat_o == last_dat &&
                        wb_we_o == last_we)
                    else report_protocol("address, data, select or we changed during a cycle");
            end
            prev_cyc = wb_cyc_o;
            held     = wb_cyc_o && wb_stb_o && !wb_ack_i;
            prev_ack = wb_ack_i;
        end
    end

    // Runs one request and checks its result and its bus cycle
    // The stall argument holds res_ready_i low for that many cycles
    task automatic run_op(input mem_op_e op, input word_t addr, input word_t data,
                          input int stall);
        reg_addr_t        wd;
        logic             wreg;
        word_t            wdata;
        word_t            r;
        word_t            cur;
        word_t            exp_result;
        word_t            exp_store;
        sel_t             exp_sel;
        logic             exp_access;
        logic             is_store;
        logic [1:0]       off;
        logic [IDX_W-1:0] idx;
        logic [7:0]       lane_b;
        logic [15:0]      lane_h;
        int               count_before;
        word_t            got;
        reg_addr_t        got_wd;
        logic             got_wreg;
        r          = next_random();
        wd         = r[4:0];
        wreg       = r[5];
        wdata      = next_random();
        off        = addr[1:0];
        idx        = addr[2 +: IDX_W];
        is_store   = op inside {OP_SB, OP_SH, OP_SW, OP_SC};
        exp_access = (op != OP_NONE) && !((op inside {OP_LH, OP_LHU, OP_SH}) && off[0]) &&
                     !((op == OP_SC) && !exp_link);
        exp_sel    = 4'b1111;
        if (op inside {OP_LB, OP_LBU, OP_SB}) begin
            exp_sel          = '0;
            exp_sel[3 - off] = 1'b1;
        end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
            exp_sel = '0;
            if (!off[0]) begin
                exp_sel[3 - off] = 1'b1;            // A half covers the byte at off and the next
                exp_sel[2 - off] = 1'b1;
            end
        end
        case (op)
            OP_SB:   exp_store = {4{data[7:0]}};
            OP_SH:   exp_store = {2{data[15:0]}};
            default: exp_store = data;
        endcase
        cur    = shadow[idx];
        lane_b = cur[8 * (3 - off) +: 8];
        lane_h = off[0] ? 16'd0 : cur[8 * (2 - off) +: 16];
        case (op)
            OP_LB:        exp_result = {{24{lane_b[7]}}, lane_b};
            OP_LBU:       exp_result = {24'd0, lane_b};
            OP_LH:        exp_result = exp_access ? {{16{lane_h[15]}}, lane_h} : '0;
            OP_LHU:       exp_result = exp_access ? {16'd0, lane_h} : '0;
            OP_LW, OP_LL: exp_result = cur;
            OP_SC:        exp_result = {31'd0, exp_link};
            default:      exp_result = wdata;
        endcase

        @(posedge clk);
        count_before     = bus_count;
        res_ready_i      <= (stall == 0);
        req_valid_i      <= 1'b1;
        req_op_i         <= op;
        req_addr_i       <= addr;
        req_store_data_i <= data;
        req_wd_i         <= wd;
        req_wreg_i       <= wreg;
        req_wdata_i      <= wdata;
        do @(negedge clk); while (!req_ready_o);
        @(posedge clk);
        req_valid_i <= 1'b0;
        do @(negedge clk); while (!res_valid_o);
        got      = res_wdata_o;
        got_wd   = res_wd_o;
        got_wreg = res_wreg_o;
        repeat (stall) begin
            @(negedge clk);
            assert (res_valid_o && !req_ready_o && res_wdata_o == got && res_wd_o == got_wd &&
                    res_wreg_o == got_wreg)
                else report_protocol("result changed or dropped while res_ready_i was low");
        end
        if (stall > 0) begin
            @(posedge clk);
            res_ready_i <= 1'b1;
        end
        @(posedge clk);                              // Result is taken on this edge

        check_word("res_wdata_o", exp_result, got);
        check_word("res_wd_o", word_t'(wd), word_t'(got_wd));
        check_word("res_wreg_o", word_t'(wreg), word_t'(got_wreg));
        if (exp_access) begin
            assert (bus_count == count_before + 1)
                else report_protocol("expected exactly one bus cycle for the access");
            check_word("wb_adr_o", addr, last_adr);
            check_word("wb_sel_o", word_t'(exp_sel), word_t'(last_sel));
            check_word("wb_we_o", word_t'(is_store), word_t'(last_we));
            if (is_store) begin
                check_word("wb_dat_o", exp_store, last_dat);
                for (int i = 0; i < 4; i++) begin
                    if (exp_sel[i]) shadow[idx][8*i +: 8] = exp_store[8*i +: 8];
                end
            end
        end else begin
            assert (bus_count == count_before)
                else report_protocol("a bus cycle ran for a request that needs none");
        end
        if (op == OP_LL) exp_link = 1'b1;
        if (op == OP_SC && exp_access) exp_link = 1'b0;
    endtask

    task automatic clear_link();
        @(posedge clk);
        llbit_clr_i <= 1'b1;
        @(posedge clk);
        llbit_clr_i <= 1'b0;
        exp_link = 1'b0;
    endtask

    initial begin
        word_t r;
        word_t base;
        clk              = 1'b0;
        arst_n_i         = 1'b0;
        req_valid_i      = 1'b0;
        req_op_i         = OP_NONE;
        req_addr_i       = '0;
        req_store_data_i = '0;
        req_wd_i         = '0;
        req_wreg_i       = 1'b0;
        req_wdata_i      = '0;
        res_ready_i      = 1'b1;
        llbit_clr_i      = 1'b0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        assert (!wb_cyc_o && !wb_stb_o && !wb_we_o && !res_valid_o && req_ready_o)
            else report_protocol("outputs are not in their reset state");

        repeat (4) run_op(OP_NONE, next_random(), next_random(), 0);

        repeat (20) begin
            r    = next_random();
            base = {24'd0, r[7:2], 2'b00};
            run_op(OP_SW, base, next_random(), 0);
            run_op(OP_LW, base, 32'd0, 0);
        end

        // Sign bit alternates so both extensions are seen
        for (int off = 0; off < 4; off++) begin
            r    = next_random();
            base = {24'd0, r[7:2], 2'b00};
            run_op(OP_SW, base, next_random(), 0);
            r = next_random();
            run_op(OP_SB, base + off, (off % 2) ? (r & ~32'h80) : (r | 32'h80), 0);
            run_op(OP_LB, base + off, 32'd0, 0);
            run_op(OP_LBU, base + off, 32'd0, 0);
            run_op(OP_LW, base, 32'd0, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            r    = next_random();
            base = {24'd0, r[7:2], 2'b00};
            run_op(OP_SW, base, next_random(), 0);
            r = next_random();
            run_op(OP_SH, base + off, off ? (r & ~32'h8000) : (r | 32'h8000), 0);
            run_op(OP_LH, base + off, 32'd0, 0);
            run_op(OP_LHU, base + off, 32'd0, 0);
            run_op(OP_LW, base, 32'd0, 0);
        end

        base = 32'h40;
        run_op(OP_SW, base, next_random(), 0);
        run_op(OP_LL, base, 32'd0, 0);
        run_op(OP_SC, base, next_random(), 0);
        run_op(OP_SC, base, next_random(), 0);     // Link already consumed
        run_op(OP_LL, base, 32'd0, 0);
        clear_link();
        run_op(OP_SC, base, next_random(), 0);
        run_op(OP_LW, base, 32'd0, 0);

        for (int off = 1; off < 4; off += 2) begin
            run_op(OP_LH, base + off, 32'd0, 0);
            run_op(OP_LHU, base + off, 32'd0, 0);
            run_op(OP_SH, base + off, next_random(), 0);
            run_op(OP_LW, base, 32'd0, 0);
        end

        run_op(OP_SW, base, next_random(), 5);
        run_op(OP_LW, base, 32'd0, 3);
        run_op(OP_NONE, base, 32'd0, 4);

        $display("Summary: %0d value errors, %0d protocol errors, %0d bus cycles",
                 value_errors, protocol_errors, bus_count);
        if (value_errors + protocol_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_wb_slave.sv */
`default_nettype none

`include "mem_config.svh"

module tb_wb_slave (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  mem_stage_pkg::word_t wb_adr_i,
    input  mem_stage_pkg::sel_t  wb_sel_i,
    input  mem_stage_pkg::word_t wb_dat_i,
    input  logic [2:0]           wait_states_i,
    output mem_stage_pkg::word_t wb_dat_o,
    output logic                 wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_stage_pkg::*;

    localparam int IDX_W = $clog2(`MEM_TB_DEPTH);

    word_t            mem [`MEM_TB_DEPTH];
    logic [2:0]       wait_cnt;
    logic [IDX_W-1:0] word_idx;

    assign word_idx = wb_adr_i[2 +: IDX_W];

    initial begin
        for (int i = 0; i < `MEM_TB_DEPTH; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1); // Every word differs from its neighbours
        end
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
        wait_cnt = '0;
    end

    // Ack is registered, so each access takes at least one cycle plus the wait states
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            wait_cnt <= '0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;
            wait_cnt <= '0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_cnt >= wait_states_i) begin
                wb_ack_o <= 1'b1;
                wb_dat_o <= mem[word_idx];
                for (int i = 0; i < `MEM_LANES; i++) begin
                    if (wb_we_i && wb_sel_i[i]) begin
                        mem[word_idx][8*i +: 8] <= wb_dat_i[8*i +: 8]; // Select bit 3 is bits 31 to 24
                    end
                end
            end else begin
                wait_cnt <= wait_cnt + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire
